/* source/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    localparam int xlen          = 32;
    localparam int reg_idx_w     = 5;
    localparam int inval_sets    = 16;
    localparam int set_idx_w     = 4;
    localparam int inval_credits = 2;
    // wide enough to hold every value from zero up to a full credit count
    localparam int credit_w      = $clog2(inval_credits + 1);

    typedef enum logic [1:0] {
        fwd_reg      = 2'b00,
        fwd_ex       = 2'b01,
        fwd_mem_alu  = 2'b10,
        fwd_mem_load = 2'b11
    } fwd_sel_e;

    typedef enum logic [1:0] {
        st_idle    = 2'b00,
        st_walk    = 2'b01,
        st_release = 2'b10
    } fence_state_e;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [xlen-1:0]      rs1_value;
        logic [xlen-1:0]      rs2_value;
    } id_ops_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic                 reg_wen;
        logic                 branch;
        logic                 jump;
        logic                 mret;
        logic                 ecall;
        logic                 fence_i;
        logic [xlen-1:0]      result;
        logic [xlen-1:0]      branch_pc;
        logic [xlen-1:0]      seq_pc;
    } ex_stage_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic                 reg_wen;
        logic                 mem_ren;
        logic [xlen-1:0]      alu_result;
        logic [xlen-1:0]      rdata;
    } mem_stage_t;

    typedef struct packed {
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mepc;
    } trap_vec_t;

    typedef struct packed {
        logic [xlen-1:0] rs1;
        logic [xlen-1:0] rs2;
    } operand_pair_t;

    typedef struct packed {
        logic            valid;
        logic            flush_ex;
        logic [xlen-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                 valid;
        logic [set_idx_w-1:0] set_idx;
    } inval_req_t;

endpackage

/* source/data_hazard.sv */
`timescale 1ns/10ps

module data_hazard (
    input  pipe_ctrl_pkg::id_ops_t    id_ops,
    input  pipe_ctrl_pkg::ex_stage_t  ex_info,
    input  pipe_ctrl_pkg::mem_stage_t mem_info,
    output pipe_ctrl_pkg::fwd_sel_e   sel_rs1,
    output pipe_ctrl_pkg::fwd_sel_e   sel_rs2
);
    import pipe_ctrl_pkg::*;

    logic ex_can_fwd;
    logic mem_can_fwd;

    // a stage can only supply a value if it will really write a register other than x0
    assign ex_can_fwd  = ex_info.valid && ex_info.reg_wen && (ex_info.rd != '0);
    assign mem_can_fwd = mem_info.valid && mem_info.reg_wen && (mem_info.rd != '0);

    function automatic fwd_sel_e pick_source(
        input logic [reg_idx_w-1:0] rs,
        input logic                 ex_ok,
        input logic [reg_idx_w-1:0] ex_rd,
        input logic                 mem_ok,
        input logic [reg_idx_w-1:0] mem_rd,
        input logic                 mem_load
    );
        fwd_sel_e sel;
        sel = fwd_reg;
        // execute holds the younger write, so it wins over memory
        if (ex_ok && (ex_rd == rs)) begin
            sel = fwd_ex;
        end else if (mem_ok && (mem_rd == rs)) begin
            sel = mem_load ? fwd_mem_load : fwd_mem_alu;
        end
        return sel;
    endfunction

    always_comb begin
        sel_rs1 = pick_source(id_ops.rs1, ex_can_fwd, ex_info.rd,
                              mem_can_fwd, mem_info.rd, mem_info.mem_ren);
        sel_rs2 = pick_source(id_ops.rs2, ex_can_fwd, ex_info.rd,
                              mem_can_fwd, mem_info.rd, mem_info.mem_ren);
    end

endmodule

/* source/pipe_control.sv */
`timescale 1ns/10ps

module pipe_control (
    input  pipe_ctrl_pkg::id_ops_t       id_ops,
    input  pipe_ctrl_pkg::ex_stage_t     ex_info,
    input  pipe_ctrl_pkg::mem_stage_t    mem_info,
    input  pipe_ctrl_pkg::trap_vec_t     trap_vec,
    input  pipe_ctrl_pkg::fwd_sel_e      sel_rs1,
    input  pipe_ctrl_pkg::fwd_sel_e      sel_rs2,
    input  logic                         fence_release,
    output pipe_ctrl_pkg::operand_pair_t fwd_ops,
    output pipe_ctrl_pkg::redirect_t     redirect
);
    import pipe_ctrl_pkg::*;

    logic branch_taken;
    logic redirect_cause;
    logic flush_cause;

    function automatic logic [xlen-1:0] mux_operand(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] reg_value,
        input logic [xlen-1:0] ex_value,
        input logic [xlen-1:0] mem_alu,
        input logic [xlen-1:0] mem_load
    );
        logic [xlen-1:0] value;
        case (sel)
            fwd_ex:       value = ex_value;
            fwd_mem_alu:  value = mem_alu;
            fwd_mem_load: value = mem_load;
            default:      value = reg_value;
        endcase
        return value;
    endfunction

    always_comb begin
        fwd_ops.rs1 = mux_operand(sel_rs1, id_ops.rs1_value, ex_info.result,
                                  mem_info.alu_result, mem_info.rdata);
        fwd_ops.rs2 = mux_operand(sel_rs2, id_ops.rs2_value, ex_info.result,
                                  mem_info.alu_result, mem_info.rdata);
    end

    // the branch unit leaves its compare outcome in bit 0 of the result
    assign branch_taken = ex_info.branch && ex_info.result[0];

    // a fence.i only redirects once the sequencer lets it go
    assign redirect_cause = branch_taken || ex_info.jump || ex_info.mret ||
                            ex_info.ecall || fence_release;

    // traps leave the instruction after them alone, everything else kills execute
    assign flush_cause = branch_taken || ex_info.jump || fence_release;

    always_comb begin
        redirect.valid    = ex_info.valid && redirect_cause;
        redirect.flush_ex = ex_info.valid && flush_cause;

        if (ex_info.jump) begin
            redirect.target = ex_info.result;
        end else if (branch_taken) begin
            redirect.target = ex_info.branch_pc;
        end else if (fence_release) begin
            redirect.target = ex_info.seq_pc;
        end else if (ex_info.mret) begin
            redirect.target = trap_vec.mepc;
        end else begin
            // ecall and anything left over go to the trap vector
            redirect.target = trap_vec.mtvec;
        end
    end

endmodule

/* source/fencei_seq.sv */
`timescale 1ns/10ps

module fencei_seq (
    input  logic                     clock,
    input  logic                     arst_n,
    input  pipe_ctrl_pkg::ex_stage_t ex_info,
    input  logic                     walk_done,
    output logic                     start,
    output logic                     hold,
    output logic                     fence_release
);
    import pipe_ctrl_pkg::*;

    fence_state_e state;
    fence_state_e state_next;
    logic         fence_seen;

    assign fence_seen = ex_info.valid && ex_info.fence_i;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (fence_seen) begin
                    state_next = st_walk;
                end
            end
            st_walk: begin
                if (walk_done) begin
                    state_next = st_release;
                end
            end
            st_release: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            start <= 1'b0;
        end else begin
            state <= state_next;
            // kicks the walker in the first walk cycle only
            start <= (state == st_idle) && fence_seen;
        end
    end

    // hold has to come up in the same cycle the fence shows up in execute,
    // otherwise decode would slip one more instruction past it
    assign hold = ((state == st_idle) && fence_seen) || (state == st_walk);

    assign fence_release = (state == st_release);

endmodule

/* source/inval_walker.sv */
`timescale 1ns/10ps

module inval_walker (
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      start,
    input  logic                      inval_credit,
    output pipe_ctrl_pkg::inval_req_t inval_req,
    output logic                      walk_done
);
    import pipe_ctrl_pkg::*;

    logic                 busy;
    logic                 all_sent;
    logic [set_idx_w-1:0] set_idx;
    logic [credit_w-1:0]  credits;
    logic                 req_fire;
    logic                 credits_full;
    logic                 last_set;

    assign credits_full = (credits == credit_w'(inval_credits));
    assign last_set     = (set_idx == set_idx_w'(inval_sets - 1));

    // the cache has no ready, a held credit is the permission to send
    assign req_fire = busy && !all_sent && (credits != '0);

    assign inval_req.valid   = req_fire;
    assign inval_req.set_idx = set_idx;

    // the walk ends only once the cache has finished every set it was sent
    assign walk_done = busy && all_sent && credits_full;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            credits <= credit_w'(inval_credits);
        end else begin
            case ({req_fire, inval_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    if (!credits_full) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            all_sent <= 1'b0;
            set_idx  <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            all_sent <= 1'b0;
            set_idx  <= '0;
        end else if (walk_done) begin
            busy <= 1'b0;
        end else if (req_fire) begin
            if (last_set) begin
                all_sent <= 1'b1;
            end else begin
                set_idx <= set_idx + 1'b1;
            end
        end
    end

endmodule

/* source/ctrl_top.sv */
`timescale 1ns/10ps

module ctrl_top (
    input  logic                         clock,
    input  logic                         arst_n,

    input  pipe_ctrl_pkg::id_ops_t       id_ops,
    input  pipe_ctrl_pkg::ex_stage_t     ex_info,
    input  pipe_ctrl_pkg::mem_stage_t    mem_info,
    input  pipe_ctrl_pkg::trap_vec_t     trap_vec,
    input  logic                         inval_credit,

    output pipe_ctrl_pkg::operand_pair_t fwd_ops,
    output pipe_ctrl_pkg::fwd_sel_e      sel_rs1,
    output pipe_ctrl_pkg::fwd_sel_e      sel_rs2,
    output pipe_ctrl_pkg::redirect_t     redirect,
    output logic                         hold,
    output pipe_ctrl_pkg::inval_req_t    inval_req
);

    logic walk_start;
    logic walk_done;
    logic fence_release;

    data_hazard data_hazard_i (
        .id_ops   (id_ops),
        .ex_info  (ex_info),
        .mem_info (mem_info),
        .sel_rs1  (sel_rs1),
        .sel_rs2  (sel_rs2)
    );

    pipe_control pipe_control_i (
        .id_ops        (id_ops),
        .ex_info       (ex_info),
        .mem_info      (mem_info),
        .trap_vec      (trap_vec),
        .sel_rs1       (sel_rs1),
        .sel_rs2       (sel_rs2),
        .fence_release (fence_release),
        .fwd_ops       (fwd_ops),
        .redirect      (redirect)
    );

    fencei_seq fencei_seq_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .ex_info       (ex_info),
        .walk_done     (walk_done),
        .start         (walk_start),
        .hold          (hold),
        .fence_release (fence_release)
    );

    inval_walker inval_walker_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .start        (walk_start),
        .inval_credit (inval_credit),
        .inval_req    (inval_req),
        .walk_done    (walk_done)
    );

endmodule

/* testbench/tb_tasks.svh */
function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
endfunction

task automatic compare_word(input string name, input logic [31:0] got,
                            input logic [31:0] want);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("ERROR %s got 0x%0h expected 0x%0h", name, got, want);
    end
endtask

task automatic idle_inputs();
    id_ops   <= '0;
    ex_info  <= '0;
    mem_info <= '0;
    trap_vec <= '0;
endtask

task automatic check_quiet();
    compare_word("hold", hold, 1'b0);
    compare_word("redirect.valid", redirect.valid, 1'b0);
    compare_word("inval_req.valid", inval_req.valid, 1'b0);
endtask

// execute wins over memory, and x0 never forwards
function automatic fwd_sel_e expected_source(input logic [reg_idx_w-1:0] rs,
                                             input ex_stage_t ex, input mem_stage_t mem);
    if (ex.valid && ex.reg_wen && ex.rd != 0 && ex.rd == rs) begin
        return fwd_ex;
    end
    if (mem.valid && mem.reg_wen && mem.rd != 0 && mem.rd == rs) begin
        return mem.mem_ren ? fwd_mem_load : fwd_mem_alu;
    end
    return fwd_reg;
endfunction

function automatic logic [xlen-1:0] expected_operand(input logic [reg_idx_w-1:0] rs,
        input logic [xlen-1:0] reg_value, input ex_stage_t ex, input mem_stage_t mem);
    case (expected_source(rs, ex, mem))
        fwd_ex:       return ex.result;
        fwd_mem_alu:  return mem.alu_result;
        fwd_mem_load: return mem.rdata;
        default:      return reg_value;
    endcase
endfunction

task automatic test_reset();
    for (int n = 0; n < 10; n++) begin
        @(negedge clock);
        check_quiet();
    end
    @(posedge clock);
    arst_n <= 1'b1;
    @(negedge clock);
    check_quiet();
endtask

task automatic test_forwarding();
    id_ops_t    ids;
    ex_stage_t  ex;
    mem_stage_t mem;
    for (int n = 0; n < 256; n++) begin
        ids = '0;
        ex  = '0;
        mem = '0;
        // a small register range makes matches, x0 and double hits frequent
        ids.valid      = 1'b1;
        ids.rs1        = reg_idx_w'(rand_below(4));
        ids.rs2        = reg_idx_w'(rand_below(4));
        ids.rs1_value  = $random(seed);
        ids.rs2_value  = $random(seed);
        ex.valid       = (rand_below(4) != 0);
        ex.reg_wen     = (rand_below(4) != 0);
        ex.rd          = reg_idx_w'(rand_below(4));
        ex.result      = $random(seed);
        mem.valid      = (rand_below(4) != 0);
        mem.reg_wen    = (rand_below(4) != 0);
        mem.mem_ren    = (rand_below(2) != 0);
        mem.rd         = reg_idx_w'(rand_below(4));
        mem.alu_result = $random(seed);
        mem.rdata      = $random(seed);
        @(posedge clock);
        id_ops   <= ids;
        ex_info  <= ex;
        mem_info <= mem;
        @(negedge clock);
        compare_word("sel_rs1", sel_rs1, expected_source(ids.rs1, ex, mem));
        compare_word("sel_rs2", sel_rs2, expected_source(ids.rs2, ex, mem));
        compare_word("fwd_ops.rs1", fwd_ops.rs1,
                     expected_operand(ids.rs1, ids.rs1_value, ex, mem));
        compare_word("fwd_ops.rs2", fwd_ops.rs2,
                     expected_operand(ids.rs2, ids.rs2_value, ex, mem));
    end
endtask

task automatic test_redirect();
    ex_stage_t       ex;
    trap_vec_t       tv;
    logic            taken;
    logic            want_valid;
    logic [xlen-1:0] want_target;
    for (int c = 0; c < 64; c++) begin
        ex           = '0;
        ex.valid     = c[0];
        ex.branch    = c[1];
        ex.result    = $random(seed);
        ex.result[0] = c[2];
        ex.jump      = c[3];
        ex.mret      = c[4];
        ex.ecall     = c[5];
        ex.branch_pc = $random(seed);
        ex.seq_pc    = $random(seed);
        tv.mtvec     = $random(seed);
        tv.mepc      = $random(seed);
        @(posedge clock);
        ex_info  <= ex;
        trap_vec <= tv;
        @(negedge clock);
        taken       = ex.branch && ex.result[0];
        want_valid  = ex.valid && (taken || ex.jump || ex.mret || ex.ecall);
        want_target = ex.jump ? ex.result : taken ? ex.branch_pc :
                      ex.mret ? tv.mepc : tv.mtvec;
        compare_word("redirect.valid", redirect.valid, want_valid);
        compare_word("redirect.flush_ex", redirect.flush_ex, ex.valid && (taken || ex.jump));
        compare_word("hold", hold, 1'b0);
        if (want_valid) begin
            compare_word("redirect.target", redirect.target, want_target);
        end
    end
endtask

task automatic fence_walk(input logic [xlen-1:0] pc);
    ex_stage_t ex;
    int        waited;
    ex           = '0;
    ex.valid     = 1'b1;
    ex.fence_i   = 1'b1;
    ex.seq_pc    = pc;
    ex.result    = $random(seed);
    ex.branch_pc = $random(seed);
    @(posedge clock);
    set_log.delete();
    ex_info <= ex;
    @(negedge clock);
    compare_word("hold", hold, 1'b1);
    compare_word("redirect.valid", redirect.valid, 1'b0);
    waited = 0;
    // the walk length depends on how fast the cache model hands credits back
    while (redirect.valid !== 1'b1 && waited < 400) begin
        @(negedge clock);
        waited++;
        if (redirect.valid !== 1'b1) begin
            compare_word("hold", hold, 1'b1);
        end
    end
    if (redirect.valid !== 1'b1) begin
        error_count++;
        $display("fence.i walk did not finish within %0d cycles", waited);
    end
endtask

task automatic fence_release(input logic [xlen-1:0] pc);
    ex_stage_t ex;
    compare_word("hold", hold, 1'b0);
    compare_word("redirect.flush_ex", redirect.flush_ex, 1'b1);
    compare_word("redirect.target", redirect.target, pc);
    compare_word("outstanding requests", outstanding, 0);
    compare_word("set count", set_log.size(), inval_sets);
    foreach (set_log[k]) begin
        compare_word("inval_req.set_idx", set_log[k], k);
    end
    // the next instruction is valid but redirects nothing, so the pulse must end
    ex        = '0;
    ex.valid  = 1'b1;
    ex.seq_pc = pc + 32'd4;
    @(posedge clock);
    ex_info <= ex;
    @(negedge clock);
    check_quiet();
endtask

/* testbench/tb_ctrl_top.sv */
`timescale 1ns/10ps

module tb_ctrl_top;
    import pipe_ctrl_pkg::*;

    logic          clock = 1'b0;
    logic          arst_n;
    id_ops_t       id_ops;
    ex_stage_t     ex_info;
    mem_stage_t    mem_info;
    trap_vec_t     trap_vec;
    logic          inval_credit = 1'b0;
    operand_pair_t fwd_ops;
    fwd_sel_e      sel_rs1;
    fwd_sel_e      sel_rs2;
    redirect_t     redirect;
    logic          hold;
    inval_req_t    inval_req;

    integer seed = 32'hfddf;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_no = 0;
    int     outstanding = 0;
    int     due_q[$];
    int     set_log[$];

    always #10 clock = ~clock;

    ctrl_top ctrl_top_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .id_ops       (id_ops),
        .ex_info      (ex_info),
        .mem_info     (mem_info),
        .trap_vec     (trap_vec),
        .inval_credit (inval_credit),
        .fwd_ops      (fwd_ops),
        .sel_rs1      (sel_rs1),
        .sel_rs2      (sel_rs2),
        .redirect     (redirect),
        .hold         (hold),
        .inval_req    (inval_req)
    );

    // the cache accepts requests at the falling edge, where the DUT outputs have settled
    always @(negedge clock) begin
        if (arst_n === 1'b1 && inval_req.valid === 1'b1) begin
            if (outstanding >= inval_credits) begin
                error_count++;
                $display("cache got set %0d while already holding %0d requests",
                         inval_req.set_idx, outstanding);
            end
            outstanding++;
            set_log.push_back(int'(inval_req.set_idx));
            due_q.push_back(cycle_no + 1 + rand_below(4));
        end
    end

    // at most one credit goes back per cycle, any request that is due may be picked
    always @(posedge clock) begin : credit_return
        int hit;
        hit = -1;
        cycle_no++;
        foreach (due_q[k]) begin
            if (hit < 0 && due_q[k] <= cycle_no) begin
                hit = k;
            end
        end
        if (hit >= 0) begin
            due_q.delete(hit);
            outstanding--;
            inval_credit <= 1'b1;
        end else begin
            inval_credit <= 1'b0;
        end
    end

    `include "tb_tasks.svh"

    initial begin
        arst_n <= 1'b0;
        idle_inputs();
        test_reset();
        test_forwarding();
        test_redirect();
        fence_walk(32'h0000_1004);
        fence_release(32'h0000_1004);
        fence_walk(32'h0000_2a48);
        fence_release(32'h0000_2a48);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+testbench
source/pipe_ctrl_pkg.sv
source/data_hazard.sv
source/pipe_control.sv
source/fencei_seq.sv
source/inval_walker.sv
source/ctrl_top.sv
testbench/tb_ctrl_top.sv
